// File: compile.f
+incdir+hdl
hdl/msu_pkg.sv
hdl/bus_strobe_sync.sv
hdl/msu_databuf.sv
hdl/msu_mcu_port.sv
hdl/msu_regs.sv
hdl/msu_top.sv
dv/msu_tb.sv

// File: dv/msu_tb.sv
`timescale 1ns/100ps

module msu_tb
  import msu_pkg::*;
();

  localparam int drive_delay   = 2;
  localparam int strobe_cycles = 6;
  // About three times the 1300 or so cycles of bus and microcontroller traffic
  localparam int watchdog_cycles = 4000;

  logic       clkin;
  logic       rst;
  logic       enable;
  logic       rd_n;
  logic       wr_n;
  reg_sel_t   reg_sel;
  byte_t      data_in;
  byte_t      data_out;
  logic       mcu_valid;
  mcu_cmd_e   mcu_cmd;
  buf_addr_t  mcu_arg;
  logic [6:0] status_out;
  byte_t      volume;
  logic       volume_latch;
  seek_addr_t seek_addr;
  track_t     track;

  integer     seed;
  int         latch_count;
  string      id_text;
  // Scoreboard of the most recent fill
  byte_t      fill_bytes [0:31];

  msu_top u_msu_top (
    .clkin        (clkin),
    .rst          (rst),
    .enable       (enable),
    .rd_n         (rd_n),
    .wr_n         (wr_n),
    .reg_sel      (reg_sel),
    .data_in      (data_in),
    .data_out     (data_out),
    .mcu_valid    (mcu_valid),
    .mcu_cmd      (mcu_cmd),
    .mcu_arg      (mcu_arg),
    .status_out   (status_out),
    .volume       (volume),
    .volume_latch (volume_latch),
    .seek_addr    (seek_addr),
    .track        (track)
  );

  initial begin
    clkin = 1'b0;
    forever #10 clkin = ~clkin;
  end

  // Volume latch pulses seen so far
  always @(posedge clkin) begin
    if (rst) begin
      latch_count <= 0;
    end else if (volume_latch) begin
      latch_count <= latch_count + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Failure reporting and checks
  ////////////////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    assert (actual === expected)
    else begin
      $display("ERROR: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      stop_with_failure();
    end
  endtask

  a_latch_single: assert property (@(posedge clkin) disable iff (rst)
    volume_latch |=> !volume_latch)
  else begin
    $display("ERROR: volume_latch high for two cycles, value 0x%0h", volume_latch);
    stop_with_failure();
  end

  // Console side is frozen while enable stays low
  a_frozen_outputs: assert property (@(posedge clkin) disable iff (rst)
    (!enable && !$past(enable)) |->
      ($stable(seek_addr) && $stable(track) && $stable(volume) &&
       $stable(data_out) && !volume_latch))
  else begin
    $display("ERROR: console output changed with enable low, seek_addr 0x%0h volume 0x%0h",
             seek_addr, volume);
    stop_with_failure();
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clkin);
    $display("Watchdog expired after %0d cycles, test sequence did not finish",
             watchdog_cycles);
    stop_with_failure();
  end

  ////////////////////////////////////////////////////////////
  // Bus and microcontroller tasks
  ////////////////////////////////////////////////////////////

  // Strobe low for six cycles, data_out sampled before release
  task automatic bus_read(input reg_sel_t sel, output byte_t value);
    @(posedge clkin);
    #drive_delay;
    reg_sel = sel;
    rd_n    = 1'b0;
    repeat (strobe_cycles) @(posedge clkin);
    #drive_delay;
    value = data_out;
    rd_n  = 1'b1;
    repeat (4) @(posedge clkin);
    #drive_delay;
  endtask

  // Select and data held until the write lands after the rising edge
  task automatic bus_write(input reg_sel_t sel, input byte_t value);
    @(posedge clkin);
    #drive_delay;
    reg_sel = sel;
    data_in = value;
    wr_n    = 1'b0;
    repeat (strobe_cycles) @(posedge clkin);
    #drive_delay;
    wr_n = 1'b1;
    repeat (6) @(posedge clkin);
    #drive_delay;
  endtask

  // Returns once the command effect is visible
  task automatic mcu_issue(input mcu_cmd_e cmd, input buf_addr_t arg);
    @(posedge clkin);
    #drive_delay;
    mcu_valid = 1'b1;
    mcu_cmd   = cmd;
    mcu_arg   = arg;
    @(posedge clkin);
    #drive_delay;
    mcu_valid = 1'b0;
    @(posedge clkin);
    #drive_delay;
  endtask

  function automatic buf_addr_t status_arg(input status_bits_t set_mask,
                                           input status_bits_t clear_mask);
    return {2'b00, set_mask, clear_mask};
  endfunction

  task automatic expect_read(input reg_sel_t sel, input byte_t expected);
    byte_t value;
    bus_read(sel, value);
    check_value($sformatf("data_out reg %0d", sel), value, expected);
  endtask

  // 32 random bytes from base, seek there, read them back in order
  task automatic fill_and_read(input buf_addr_t base);
    logic [31:0] rand_word;
    buf_addr_t   ptr;
    mcu_issue(CMD_FILL_ADDR, base);
    for (int i = 0; i < 32; i++) begin
      rand_word     = $random(seed);
      fill_bytes[i] = rand_word[7:0];
      mcu_issue(CMD_FILL_DATA, {6'b000000, fill_bytes[i]});
    end
    mcu_issue(CMD_SEEK_PTR, base);
    check_value("status_out[6]", status_out[6], base[13]);
    for (int i = 0; i < 32; i++) begin
      ptr = base + i[13:0];
      check_value("status_out[6]", status_out[6], ptr[13]);
      expect_read(3'd1, fill_bytes[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rand_word;
    seek_addr_t  seek_value;
    int          count_before;
    byte_t       held_data;
    rst       = 1'b1;
    enable    = 1'b1;
    rd_n      = 1'b1;
    wr_n      = 1'b1;
    reg_sel   = '0;
    data_in   = '0;
    mcu_valid = 1'b0;
    mcu_cmd   = CMD_FILL_ADDR;
    mcu_arg   = '0;
    seed      = 32'h6f8f_1fb4;
    id_text   = "S-MSU1";
    repeat (3) @(posedge clkin);
    #drive_delay;
    rst = 1'b0;

    // Reset state, both busy bits set
    check_value("status_out", status_out, 7'h00);
    expect_read(3'd0, 8'hc1);
    for (int i = 0; i < 6; i++) begin
      expect_read(reg_sel_t'(i + 2), byte_t'(id_text[i]));
    end

    // Buffer fill at a random spot, then across the top of the buffer
    rand_word = $random(seed);
    fill_and_read(rand_word[13:0]);
    fill_and_read(14'h3ff0);
    check_value("status_out", status_out, 7'h00);

    // Data seek request
    mcu_issue(CMD_STATUS, status_arg(6'h00, 6'h10));
    expect_read(3'd0, 8'h41);
    seek_value = $random(seed);
    bus_write(3'd0, seek_value[7:0]);
    bus_write(3'd1, seek_value[15:8]);
    bus_write(3'd2, seek_value[23:16]);
    bus_write(3'd3, seek_value[31:24]);
    check_value("seek_addr", seek_addr, seek_value);
    check_value("status_out", status_out, 7'h10);
    expect_read(3'd0, 8'hc1);
    mcu_issue(CMD_STATUS, status_arg(6'h00, 6'h10));
    check_value("status_out", status_out, 7'h00);
    expect_read(3'd0, 8'h41);

    // Track start and volume
    bus_write(3'd4, 8'h5a);
    bus_write(3'd5, 8'h01);
    check_value("track", track, 16'h015a);
    check_value("status_out", status_out, 7'h20);
    count_before = latch_count;
    bus_write(3'd6, 8'hb7);
    check_value("volume", volume, 8'hb7);
    check_value("volume_latch pulses", latch_count - count_before, 1);

    // Playback control locked out until audio busy clears
    bus_write(3'd7, 8'h02);
    check_value("status_out", status_out, 7'h20);
    mcu_issue(CMD_STATUS, status_arg(6'h00, 6'h20));
    check_value("status_out", status_out, 7'h00);
    expect_read(3'd0, 8'h01);
    bus_write(3'd7, 8'h02);
    check_value("status_out", status_out, 7'h05);

    // Error and state bits through the set mask, clear wins on overlap
    mcu_issue(CMD_STATUS, status_arg(6'h0c, 6'h01));
    check_value("status_out", status_out, 7'h04);
    expect_read(3'd0, 8'h29);
    mcu_issue(CMD_STATUS, status_arg(6'h03, 6'h0e));
    check_value("status_out", status_out, 7'h05);
    expect_read(3'd0, 8'h01);

    // Disabled console access
    mcu_issue(CMD_SEEK_PTR, 14'h3ffe);
    check_value("status_out", status_out, 7'h45);
    @(posedge clkin);
    #drive_delay;
    enable    = 1'b0;
    held_data = data_out;
    bus_write(3'd0, ~seek_value[7:0]);
    bus_write(3'd4, 8'hff);
    bus_write(3'd6, 8'h11);
    check_value("seek_addr", seek_addr, seek_value);
    check_value("track", track, 16'h015a);
    check_value("volume", volume, 8'hb7);
    expect_read(3'd1, held_data);
    check_value("status_out", status_out, 7'h45);
    @(posedge clkin);
    #drive_delay;
    enable = 1'b1;
    expect_read(3'd1, fill_bytes[14]);
    check_value("status_out", status_out, 7'h45);
    expect_read(3'd1, fill_bytes[15]);
    check_value("status_out", status_out, 7'h05);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: hdl/bus_strobe_sync.sv
`timescale 1ns/100ps
`include "msu_config.svh"

module bus_strobe_sync (
  input  logic clkin,
  input  logic rst,
  input  logic rd_n,
  input  logic wr_n,
  output logic oe_falling,
  output logic oe_rising,
  output logic we_rising
);

  localparam int STAGES = `MSU_SYNC_STAGES;

  // Synchronizer stages in the low bits, edge register on top
  logic [STAGES:0] rd_sreg;
  logic [STAGES:0] wr_sreg;

  ////////////////////////////////////////////////////////////
  // Synchronizer chains
  ////////////////////////////////////////////////////////////

  // Idle level is high, so reset loads ones and no edge follows
  always_ff @(posedge clkin) begin
    if (rst) begin
      rd_sreg <= '1;
      wr_sreg <= '1;
    end else begin
      rd_sreg <= {rd_sreg[STAGES-1:0], rd_n};
      wr_sreg <= {wr_sreg[STAGES-1:0], wr_n};
    end
  end

  ////////////////////////////////////////////////////////////
  // Edge pulses
  ////////////////////////////////////////////////////////////

  // Compare last sync stage against the edge register
  always_ff @(posedge clkin) begin
    if (rst) begin
      oe_falling <= 1'b0;
      oe_rising  <= 1'b0;
      we_rising  <= 1'b0;
    end else begin
      oe_falling <= rd_sreg[STAGES] & ~rd_sreg[STAGES-1];
      oe_rising  <= ~rd_sreg[STAGES] & rd_sreg[STAGES-1];
      we_rising  <= ~wr_sreg[STAGES] & wr_sreg[STAGES-1];
    end
  end

endmodule

// File: hdl/msu_config.svh
`ifndef MSU_CONFIG_SVH
`define MSU_CONFIG_SVH

// Data buffer geometry, 16 KiB of byte storage
`define MSU_BUF_AW    14
`define MSU_BUF_DEPTH (1 << `MSU_BUF_AW)

// Flip-flops per strobe before the edge register
`define MSU_SYNC_STAGES 2

////////////////////////////////////////////////////////////
// Identification string "S-MSU1", registers 2 to 7
////////////////////////////////////////////////////////////

`define MSU_ID0 8'h53
`define MSU_ID1 8'h2d
`define MSU_ID2 8'h4d
`define MSU_ID3 8'h53
`define MSU_ID4 8'h55
`define MSU_ID5 8'h31

`endif

// File: hdl/msu_databuf.sv
`timescale 1ns/100ps
`include "msu_config.svh"

module msu_databuf
  import msu_pkg::*;
(
  input  logic      clkin,
  input  logic      we,
  input  buf_addr_t waddr,
  input  byte_t     wdata,
  input  buf_addr_t raddr,
  output byte_t     rdata
);

  // Byte storage filled by the microcontroller
  byte_t mem [0:`MSU_BUF_DEPTH-1];

  // Write port
  always_ff @(posedge clkin) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Read port, one cycle of latency
  // old data is returned when both ports hit the same address
  always_ff @(posedge clkin) begin
    rdata <= mem[raddr];
  end

endmodule

// File: hdl/msu_mcu_port.sv
`timescale 1ns/100ps

module msu_mcu_port
  import msu_pkg::*;
(
  input  logic         clkin,
  input  logic         rst,
  input  logic         mcu_valid,
  input  mcu_cmd_e     mcu_cmd,
  input  buf_addr_t    mcu_arg,
  output logic         buf_we,
  output buf_addr_t    buf_waddr,
  output byte_t        buf_wdata,
  output logic         ptr_load,
  output buf_addr_t    ptr_value,
  output logic         status_we,
  output status_bits_t status_set,
  output status_bits_t status_clear
);

  // Next buffer location for CMD_FILL_DATA
  buf_addr_t fill_addr;

  ////////////////////////////////////////////////////////////
  // Fill address
  ////////////////////////////////////////////////////////////

  // Wraps at the buffer size through the natural pointer width
  always_ff @(posedge clkin) begin
    if (rst) begin
      fill_addr <= '0;
    end else if (mcu_valid) begin
      if (mcu_cmd == CMD_FILL_ADDR) begin
        fill_addr <= mcu_arg;
      end else if (mcu_cmd == CMD_FILL_DATA) begin
        fill_addr <= fill_addr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////////////////////////

  // Single-cycle strobes
  always_ff @(posedge clkin) begin
    if (rst) begin
      buf_we    <= 1'b0;
      ptr_load  <= 1'b0;
      status_we <= 1'b0;
    end else begin
      buf_we    <= mcu_valid && (mcu_cmd == CMD_FILL_DATA);
      ptr_load  <= mcu_valid && (mcu_cmd == CMD_SEEK_PTR);
      status_we <= mcu_valid && (mcu_cmd == CMD_STATUS);
    end
  end

  // Payload, only meaningful alongside its strobe
  always_ff @(posedge clkin) begin
    if (mcu_valid) begin
      buf_waddr    <= fill_addr;
      buf_wdata    <= mcu_arg[7:0];
      ptr_value    <= mcu_arg;
      status_set   <= mcu_arg[11:6];
      status_clear <= mcu_arg[5:0];
    end
  end

  // One request kind per cycle toward the register file and buffer
  a_one_strobe: assert property (@(posedge clkin) disable iff (rst)
    $onehot0({buf_we, ptr_load, status_we}));

endmodule

// File: hdl/msu_pkg.sv
`include "msu_config.svh"

package msu_pkg;

  // Console bus byte
  typedef logic [7:0] byte_t;

  // Pointer into the data buffer
  typedef logic [`MSU_BUF_AW-1:0] buf_addr_t;

  // Console register number
  typedef logic [2:0] reg_sel_t;

  // Media seek address and audio track
  typedef logic [31:0] seek_addr_t;
  typedef logic [15:0] track_t;

  // Status set or clear mask
  //   5 audio busy, 4 data busy, 3 audio error
  //   2:1 audio state, 0 control start
  typedef logic [5:0] status_bits_t;

  // Microcontroller commands
  typedef enum logic [1:0] {
    CMD_FILL_ADDR = 2'd0,
    CMD_FILL_DATA = 2'd1,
    CMD_SEEK_PTR  = 2'd2,
    CMD_STATUS    = 2'd3
  } mcu_cmd_e;

endpackage

// File: hdl/msu_regs.sv
`timescale 1ns/100ps
`include "msu_config.svh"

module msu_regs
  import msu_pkg::*;
(
  input  logic         clkin,
  input  logic         rst,
  input  logic         enable,
  input  logic         oe_falling,
  input  logic         we_rising,
  input  reg_sel_t     reg_sel,
  input  byte_t        data_in,
  input  byte_t        buf_rdata,
  input  logic         ptr_load,
  input  buf_addr_t    ptr_value,
  input  logic         status_we,
  input  status_bits_t status_set,
  input  status_bits_t status_clear,
  output byte_t        data_out,
  output buf_addr_t    buf_raddr,
  output logic [6:0]   status_out,
  output byte_t        volume,
  output logic         volume_latch,
  output seek_addr_t   seek_addr,
  output track_t       track
);

  logic      reg_read;
  logic      reg_write;
  buf_addr_t rd_ptr;

  // Request handshake, console sets and microcontroller clears
  logic data_start;
  logic data_busy;
  logic audio_start;
  logic audio_busy;
  logic ctrl_start;

  // Playback state reported back to the console
  logic       audio_error;
  logic [1:0] audio_state;
  logic [1:0] audio_ctrl;

  assign reg_read  = oe_falling & enable;
  assign reg_write = we_rising & enable;

  assign buf_raddr = rd_ptr;

  assign status_out = {rd_ptr[`MSU_BUF_AW-1],
                       audio_start,
                       data_start,
                       volume_latch,
                       audio_ctrl,
                       ctrl_start};

  ////////////////////////////////////////////////////////////
  // Read pointer and read data
  ////////////////////////////////////////////////////////////

  // Pointer load takes priority over a data read
  always_ff @(posedge clkin) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (ptr_load) begin
      rd_ptr <= ptr_value;
    end else if (reg_read && (reg_sel == 3'd1)) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // buf_rdata already holds the byte at the pointer before the increment
  always_ff @(posedge clkin) begin
    if (rst) begin
      data_out <= '0;
    end else if (reg_read) begin
      case (reg_sel)
        3'd0: data_out <= {data_busy, audio_busy, audio_state, audio_error, 3'b001};
        3'd1: data_out <= buf_rdata;
        3'd2: data_out <= `MSU_ID0;
        3'd3: data_out <= `MSU_ID1;
        3'd4: data_out <= `MSU_ID2;
        3'd5: data_out <= `MSU_ID3;
        3'd6: data_out <= `MSU_ID4;
        3'd7: data_out <= `MSU_ID5;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Register writes and status updates
  ////////////////////////////////////////////////////////////

  // A console write in the same cycle drops the status update
  always_ff @(posedge clkin) begin
    if (rst) begin
      seek_addr   <= '0;
      track       <= '0;
      volume      <= '0;
      data_start  <= 1'b0;
      data_busy   <= 1'b1;
      audio_start <= 1'b0;
      audio_busy  <= 1'b1;
      ctrl_start  <= 1'b0;
      audio_error <= 1'b0;
      audio_state <= 2'b00;
      audio_ctrl  <= 2'b00;
    end else if (reg_write) begin
      case (reg_sel)
        3'd0: seek_addr[7:0]   <= data_in;
        3'd1: seek_addr[15:8]  <= data_in;
        3'd2: seek_addr[23:16] <= data_in;
        3'd3: begin
          seek_addr[31:24] <= data_in;
          data_start       <= 1'b1;
          data_busy        <= 1'b1;
        end
        3'd4: track[7:0] <= data_in;
        3'd5: begin
          track[15:8] <= data_in;
          audio_start <= 1'b1;
          audio_busy  <= 1'b1;
        end
        3'd6: volume <= data_in;
        3'd7: begin
          // Playback control is locked out while a track start is pending
          if (!audio_busy) begin
            audio_ctrl <= data_in[1:0];
            ctrl_start <= 1'b1;
          end
        end
      endcase
    end else if (status_we) begin
      audio_busy  <= (audio_busy | status_set[5]) & ~status_clear[5];
      data_busy   <= (data_busy | status_set[4]) & ~status_clear[4];
      audio_error <= (audio_error | status_set[3]) & ~status_clear[3];
      audio_state <= (audio_state | status_set[2:1]) & ~status_clear[2:1];
      ctrl_start  <= (ctrl_start | status_set[0]) & ~status_clear[0];
      // Finishing a request retires its start bit too
      if (status_clear[5]) begin
        audio_start <= 1'b0;
      end
      if (status_clear[4]) begin
        data_start <= 1'b0;
      end
    end
  end

  // One-cycle pulse per volume write
  always_ff @(posedge clkin) begin
    if (rst) begin
      volume_latch <= 1'b0;
    end else begin
      volume_latch <= reg_write && (reg_sel == 3'd6);
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  a_latch_pulse: assert property (@(posedge clkin) disable iff (rst)
    volume_latch |=> !volume_latch);

  // Pointer moves only on a microcontroller seek or a console data read
  a_ptr_cause: assert property (@(posedge clkin) disable iff (rst)
    $changed(rd_ptr) |-> $past(ptr_load || (reg_read && (reg_sel == 3'd1))));

endmodule

// File: hdl/msu_top.sv
`timescale 1ns/100ps

module msu_top
  import msu_pkg::*;
(
  input  logic       clkin,
  input  logic       rst,
  input  logic       enable,
  // Console bus
  input  logic       rd_n,
  input  logic       wr_n,
  input  reg_sel_t   reg_sel,
  input  byte_t      data_in,
  output byte_t      data_out,
  // Microcontroller port
  input  logic       mcu_valid,
  input  mcu_cmd_e   mcu_cmd,
  input  buf_addr_t  mcu_arg,
  // Request outputs
  output logic [6:0] status_out,
  output byte_t      volume,
  output logic       volume_latch,
  output seek_addr_t seek_addr,
  output track_t     track
);

  logic         oe_falling;
  logic         we_rising;

  logic         buf_we;
  buf_addr_t    buf_waddr;
  byte_t        buf_wdata;
  buf_addr_t    buf_raddr;
  byte_t        buf_rdata;

  logic         ptr_load;
  buf_addr_t    ptr_value;
  logic         status_we;
  status_bits_t status_set;
  status_bits_t status_clear;

  ////////////////////////////////////////////////////////////
  // Console strobes
  ////////////////////////////////////////////////////////////

  // End of read cycle is not needed by the register file
  bus_strobe_sync u_strobe_sync (
    .clkin      (clkin),
    .rst        (rst),
    .rd_n       (rd_n),
    .wr_n       (wr_n),
    .oe_falling (oe_falling),
    .oe_rising  (),
    .we_rising  (we_rising)
  );

  msu_mcu_port u_mcu_port (
    .clkin        (clkin),
    .rst          (rst),
    .mcu_valid    (mcu_valid),
    .mcu_cmd      (mcu_cmd),
    .mcu_arg      (mcu_arg),
    .buf_we       (buf_we),
    .buf_waddr    (buf_waddr),
    .buf_wdata    (buf_wdata),
    .ptr_load     (ptr_load),
    .ptr_value    (ptr_value),
    .status_we    (status_we),
    .status_set   (status_set),
    .status_clear (status_clear)
  );

  msu_databuf u_databuf (
    .clkin (clkin),
    .we    (buf_we),
    .waddr (buf_waddr),
    .wdata (buf_wdata),
    .raddr (buf_raddr),
    .rdata (buf_rdata)
  );

  msu_regs u_regs (
    .clkin        (clkin),
    .rst          (rst),
    .enable       (enable),
    .oe_falling   (oe_falling),
    .we_rising    (we_rising),
    .reg_sel      (reg_sel),
    .data_in      (data_in),
    .buf_rdata    (buf_rdata),
    .ptr_load     (ptr_load),
    .ptr_value    (ptr_value),
    .status_we    (status_we),
    .status_set   (status_set),
    .status_clear (status_clear),
    .data_out     (data_out),
    .buf_raddr    (buf_raddr),
    .status_out   (status_out),
    .volume       (volume),
    .volume_latch (volume_latch),
    .seek_addr    (seek_addr),
    .track        (track)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module msu_tb -o msu_sim \
  && ./obj_dir/msu_sim | tee /dev/stderr | grep -q "Simulation PASSED" \
  && echo "run.sh: simulation run succeeded" \
  || { echo "run.sh: simulation run did not succeed"; exit 1; }
